//--- design/int_issue_pkg.sv
package int_issue_pkg;

    localparam int data_width   = 32;
    localparam int rob_id_width = 5;

    typedef logic [rob_id_width-1:0] rob_id_t;
    typedef logic [data_width-1:0]   reg_data_t;

    // {funct7[5], funct3} of the matching rv32i op
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b1000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_sra  = 4'b1101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111
    } alu_op_t;

    // one slot of the issue queue
    typedef struct packed {
        logic      src1_valid;      // low when the op reads no rs1
        rob_id_t   src1_rob_id;     // producer tag while waiting
        logic      src1_ready;
        reg_data_t src1_data;
        logic      src2_valid;
        rob_id_t   src2_rob_id;
        logic      src2_ready;
        reg_data_t src2_data;
        logic      use_imm;         // op b comes from imm
        reg_data_t imm;
        alu_op_t   alu_op;
        logic      dst_valid;       // writes a register, so broadcast the result
        rob_id_t   instr_rob_id;
    } iiq_entry_t;

    // what the ALU needs from a scheduled entry
    typedef struct packed {
        reg_data_t src1_data;
        reg_data_t src2_data;
        reg_data_t imm;
        logic      use_imm;
        alu_op_t   alu_op;
        logic      dst_valid;
        rob_id_t   instr_rob_id;
    } iiq_issue_data_t;

endpackage

//--- design/shift_queue.sv
module shift_queue #(
    parameter int n_entries = 8
) (
    input  logic clk,
    input  logic rst_n,

    input  logic                                      enq_valid,
    output logic                                      enq_ready,
    input  int_issue_pkg::iiq_entry_t                 enq_data,

    input  logic [n_entries-1:0]                      deq_sel_onehot,
    output logic                                      deq_valid,
    output int_issue_pkg::iiq_entry_t                 deq_data,

    input  logic [n_entries-1:0]                      wr_en,
    input  int_issue_pkg::iiq_entry_t [n_entries-1:0] wr_data,

    output int_issue_pkg::iiq_entry_t [n_entries-1:0] entry_douts,
    output logic [n_entries-1:0]                      entry_valids,

    input  logic                                      flush
);

    int_issue_pkg::iiq_entry_t [n_entries-1:0] entry_q;
    logic [n_entries-1:0]                      entry_valid_q;

    int_issue_pkg::iiq_entry_t [n_entries:0]   upd_data;   // top slot is an empty spare
    logic [n_entries:0]                        upd_valid;
    logic [n_entries-1:0]                      deq_hit;
    logic [n_entries-1:0]                      shift_mask;
    int_issue_pkg::iiq_entry_t [n_entries-1:0] nxt_data;
    logic [n_entries-1:0]                      nxt_valid;
    logic                                      enq_fire;

    assign enq_ready = ~entry_valid_q[n_entries-1];   // slots fill from 0 up
    assign enq_fire  = enq_valid & enq_ready;
    assign deq_hit   = deq_sel_onehot & entry_valid_q;
    assign deq_valid = |deq_hit;

    assign entry_douts  = entry_q;
    assign entry_valids = entry_valid_q;

    always_comb begin
        deq_data = entry_q[0];
        for (int i = 0; i < n_entries; i++) begin
            if (deq_hit[i]) deq_data = entry_q[i];
        end
    end

    // in-place rewrite for wakeup and capture
    always_comb begin
        upd_data[n_entries]  = '0;
        upd_valid[n_entries] = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            upd_data[i]  = wr_en[i] ? wr_data[i] : entry_q[i];
            upd_valid[i] = entry_valid_q[i];
        end
    end

    // every slot at or above the dequeued one pulls from its neighbour
    always_comb begin
        shift_mask[0] = deq_hit[0];
        for (int i = 1; i < n_entries; i++) begin
            shift_mask[i] = shift_mask[i-1] | deq_hit[i];
        end
    end

    always_comb begin : collapse_enq
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            if (shift_mask[i]) begin
                nxt_data[i]  = upd_data[i+1];
                nxt_valid[i] = upd_valid[i+1];
            end else begin
                nxt_data[i]  = upd_data[i];
                nxt_valid[i] = upd_valid[i];
            end
            // new entry goes behind the youngest survivor
            if (enq_fire && !nxt_valid[i] && !placed) begin
                nxt_data[i]  = enq_data;
                nxt_valid[i] = 1'b1;
                placed       = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid_q <= '0;
        end else if (flush) begin
            entry_valid_q <= '0;
        end else begin
            entry_valid_q <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= nxt_data;
    end

    // scheduler picks at most one slot
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(deq_sel_onehot));

    // an accepted entry always finds a free slot, so occupancy tracks the handshakes
    assert property (@(posedge clk) disable iff (!rst_n)
        enq_fire && !flush |=> $countones(entry_valid_q) ==
            $past($countones(entry_valid_q)) + 1 - int'($past(deq_valid)));

endmodule

//--- design/integer_alu.sv
module integer_alu (
    input  logic                           issue_valid,
    input  int_issue_pkg::rob_id_t         issue_rob_id,
    input  int_issue_pkg::iiq_issue_data_t issue_data,

    output logic                           alu_broadcast_valid,
    output int_issue_pkg::rob_id_t         alu_broadcast_rob_id,
    output int_issue_pkg::reg_data_t       alu_broadcast_reg_data
);

    int_issue_pkg::reg_data_t                      op_a;
    int_issue_pkg::reg_data_t                      op_b;
    int_issue_pkg::reg_data_t                      result;
    logic [$clog2(int_issue_pkg::data_width)-1:0] shamt;

    assign op_a  = issue_data.src1_data;
    assign op_b  = issue_data.use_imm ? issue_data.imm : issue_data.src2_data;
    assign shamt = op_b[$clog2(int_issue_pkg::data_width)-1:0];   // rv32 uses 5 bits

    always_comb begin
        unique case (issue_data.alu_op)
            int_issue_pkg::alu_add: begin
                result = op_a + op_b;
            end
            int_issue_pkg::alu_sub: begin
                result = op_a - op_b;
            end
            int_issue_pkg::alu_sll: begin
                result = op_a << shamt;
            end
            int_issue_pkg::alu_slt: begin
                result = int_issue_pkg::reg_data_t'($signed(op_a) < $signed(op_b));
            end
            int_issue_pkg::alu_sltu: begin
                result = int_issue_pkg::reg_data_t'(op_a < op_b);
            end
            int_issue_pkg::alu_xor: begin
                result = op_a ^ op_b;
            end
            int_issue_pkg::alu_srl: begin
                result = op_a >> shamt;
            end
            int_issue_pkg::alu_sra: begin
                result = int_issue_pkg::reg_data_t'($signed(op_a) >>> shamt);
            end
            int_issue_pkg::alu_or: begin
                result = op_a | op_b;
            end
            int_issue_pkg::alu_and: begin
                result = op_a & op_b;
            end
            default: begin
                result = '0;   // unused encodings
            end
        endcase
    end

    // no destination means nobody waits on this op
    assign alu_broadcast_valid    = issue_valid && issue_data.dst_valid;
    assign alu_broadcast_rob_id   = issue_rob_id;
    assign alu_broadcast_reg_data = result;

endmodule

//--- design/integer_issue.sv
module integer_issue #(
    parameter int n_entries = 8
) (
    input  logic clk,
    input  logic rst_n,

    input  logic                           dispatch_valid,
    output logic                           dispatch_ready,
    input  int_issue_pkg::iiq_entry_t      dispatch_data,

    output logic                           issue_valid,
    output int_issue_pkg::rob_id_t         issue_rob_id,
    output int_issue_pkg::iiq_issue_data_t issue_data,

    input  logic                           alu_broadcast_valid,
    input  int_issue_pkg::rob_id_t         alu_broadcast_rob_id,
    input  int_issue_pkg::reg_data_t       alu_broadcast_reg_data,

    input  logic                           ld_broadcast_valid,
    input  int_issue_pkg::rob_id_t         ld_broadcast_rob_id,
    input  int_issue_pkg::reg_data_t       ld_broadcast_reg_data,

    input  logic                           fetch_redirect_valid
);

    int_issue_pkg::iiq_entry_t [n_entries-1:0] entries;
    logic [n_entries-1:0]                      entry_valids;
    logic [n_entries-1:0]                      entries_ready;
    logic [n_entries-1:0]                      sched_onehot;
    logic                                      sched_valid;
    int_issue_pkg::iiq_entry_t                 sched_entry;
    logic                                      wake_en;
    logic [n_entries-1:0]                      entries_wr_en;
    int_issue_pkg::iiq_entry_t [n_entries-1:0] entries_wr_data;
    int_issue_pkg::iiq_entry_t                 enq_entry;
    int_issue_pkg::iiq_issue_data_t            buf_din;

    // wakeup by the op issuing now, or a result on either broadcast
    function automatic logic src_hit(input logic v, input int_issue_pkg::rob_id_t tag);
        return v && ((wake_en && tag == sched_entry.instr_rob_id) ||
                     (alu_broadcast_valid && tag == alu_broadcast_rob_id) ||
                     (ld_broadcast_valid && tag == ld_broadcast_rob_id));
    endfunction

    function automatic int_issue_pkg::reg_data_t src_data(
        input int_issue_pkg::rob_id_t   tag,
        input int_issue_pkg::reg_data_t stored
    );
        if (alu_broadcast_valid && tag == alu_broadcast_rob_id) return alu_broadcast_reg_data;
        if (ld_broadcast_valid && tag == ld_broadcast_rob_id) return ld_broadcast_reg_data;
        return stored;
    endfunction

    function automatic int_issue_pkg::iiq_entry_t rewrite(input int_issue_pkg::iiq_entry_t e);
        int_issue_pkg::iiq_entry_t r;
        r = e;
        if (src_hit(e.src1_valid, e.src1_rob_id)) begin
            r.src1_ready = 1'b1;
            r.src1_data  = src_data(e.src1_rob_id, e.src1_data);
        end
        if (src_hit(e.src2_valid, e.src2_rob_id)) begin
            r.src2_ready = 1'b1;
            r.src2_data  = src_data(e.src2_rob_id, e.src2_data);
        end
        return r;
    endfunction

    shift_queue #(
        .n_entries(n_entries)
    ) iiq (
        .clk           (clk),
        .rst_n         (rst_n),
        .enq_valid     (dispatch_valid),
        .enq_ready     (dispatch_ready),
        .enq_data      (enq_entry),
        .deq_sel_onehot(sched_onehot),
        .deq_valid     (sched_valid),
        .deq_data      (sched_entry),
        .wr_en         (entries_wr_en),
        .wr_data       (entries_wr_data),
        .entry_douts   (entries),
        .entry_valids  (entry_valids),
        .flush         (fetch_redirect_valid)
    );

    for (genvar i = 0; i < n_entries; i++) begin : g_ready
        assign entries_ready[i] = entry_valids[i] &&
                                  (!entries[i].src1_valid || entries[i].src1_ready) &&
                                  (!entries[i].src2_valid || entries[i].src2_ready);
    end

    assign sched_onehot = entries_ready & -entries_ready;   // lowest index is oldest

    // consumers of a producer without a destination never wait on it
    assign wake_en = sched_valid && sched_entry.dst_valid;

    always_comb begin
        for (int i = 0; i < n_entries; i++) begin
            entries_wr_en[i]   = entry_valids[i] &&
                                 (src_hit(entries[i].src1_valid, entries[i].src1_rob_id) ||
                                  src_hit(entries[i].src2_valid, entries[i].src2_rob_id));
            entries_wr_data[i] = rewrite(entries[i]);
        end
        enq_entry = rewrite(dispatch_data);   // landing entries see this cycle's broadcasts too
    end

    always_comb begin
        buf_din.src1_data    = sched_entry.src1_valid ?
                               src_data(sched_entry.src1_rob_id, sched_entry.src1_data) :
                               sched_entry.src1_data;
        buf_din.src2_data    = sched_entry.src2_valid ?
                               src_data(sched_entry.src2_rob_id, sched_entry.src2_data) :
                               sched_entry.src2_data;
        buf_din.imm          = sched_entry.imm;
        buf_din.use_imm      = sched_entry.use_imm;
        buf_din.alu_op       = sched_entry.alu_op;
        buf_din.dst_valid    = sched_entry.dst_valid;
        buf_din.instr_rob_id = sched_entry.instr_rob_id;
    end

    // issue buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= sched_valid && !fetch_redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sched_valid) begin
            issue_rob_id <= sched_entry.instr_rob_id;
            issue_data   <= buf_din;
        end
    end

    // a source woken by last cycle's pick finds that producer on the alu broadcast
    assert property (@(posedge clk) disable iff (!rst_n)
        sched_valid && $past(wake_en) &&
        ((sched_entry.src1_valid &&
          sched_entry.src1_rob_id == $past(sched_entry.instr_rob_id)) ||
         (sched_entry.src2_valid &&
          sched_entry.src2_rob_id == $past(sched_entry.instr_rob_id)))
        |-> alu_broadcast_valid && alu_broadcast_rob_id == $past(sched_entry.instr_rob_id));

endmodule

//--- design/int_exec_top.sv
module int_exec_top #(
    parameter int n_entries = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      dispatch_valid,
    output logic                      dispatch_ready,
    input  int_issue_pkg::iiq_entry_t dispatch_data,

    input  logic                      ld_broadcast_valid,
    input  int_issue_pkg::rob_id_t    ld_broadcast_rob_id,
    input  int_issue_pkg::reg_data_t  ld_broadcast_reg_data,

    input  logic                      fetch_redirect_valid,

    output logic                      result_valid,
    output int_issue_pkg::rob_id_t    result_rob_id,
    output int_issue_pkg::reg_data_t  result_data
);

    logic                           issue_valid;
    int_issue_pkg::rob_id_t         issue_rob_id;
    int_issue_pkg::iiq_issue_data_t issue_data;

    integer_issue #(
        .n_entries(n_entries)
    ) u_issue (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .dispatch_valid        (dispatch_valid),
        .dispatch_ready        (dispatch_ready),
        .dispatch_data         (dispatch_data),
        .issue_valid           (issue_valid),
        .issue_rob_id          (issue_rob_id),
        .issue_data            (issue_data),
        .alu_broadcast_valid   (result_valid),    // alu result loops back for wakeup
        .alu_broadcast_rob_id  (result_rob_id),
        .alu_broadcast_reg_data(result_data),
        .ld_broadcast_valid    (ld_broadcast_valid),
        .ld_broadcast_rob_id   (ld_broadcast_rob_id),
        .ld_broadcast_reg_data (ld_broadcast_reg_data),
        .fetch_redirect_valid  (fetch_redirect_valid)
    );

    integer_alu u_alu (
        .issue_valid           (issue_valid),
        .issue_rob_id          (issue_rob_id),
        .issue_data            (issue_data),
        .alu_broadcast_valid   (result_valid),
        .alu_broadcast_rob_id  (result_rob_id),
        .alu_broadcast_reg_data(result_data)
    );

endmodule

//--- test/int_exec_tb.sv
module int_exec_tb;

    localparam int n_entries = 8;
    localparam int wait_limit = 200;   // cycles for any single wait

    logic                      clk;
    logic                      rst_n;
    logic                      dispatch_valid;
    logic                      dispatch_ready;
    int_issue_pkg::iiq_entry_t dispatch_data;
    logic                      ld_broadcast_valid;
    int_issue_pkg::rob_id_t    ld_broadcast_rob_id;
    int_issue_pkg::reg_data_t  ld_broadcast_reg_data;
    logic                      fetch_redirect_valid;
    logic                      result_valid;
    int_issue_pkg::rob_id_t    result_rob_id;
    int_issue_pkg::reg_data_t  result_data;

    // model map per ROB id: expected value, dispatches and results seen
    int_issue_pkg::reg_data_t exp_val [32];
    logic [7:0]               issued_cnt [32];
    logic [7:0]               done_cnt [32];
    logic [31:0]              waiting;   // blocked on a load not yet broadcast
    int_issue_pkg::rob_id_t   order_ids [n_entries];
    int                       result_count;
    int                       order_base;
    logic                     ordered;
    logic                     after_reset;
    logic                     expect_full;
    logic [31:0]              lfsr;
    int_issue_pkg::rob_id_t   next_id;

    int_exec_top #(
        .n_entries(n_entries)
    ) uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .dispatch_valid       (dispatch_valid),
        .dispatch_ready       (dispatch_ready),
        .dispatch_data        (dispatch_data),
        .ld_broadcast_valid   (ld_broadcast_valid),
        .ld_broadcast_rob_id  (ld_broadcast_rob_id),
        .ld_broadcast_reg_data(ld_broadcast_reg_data),
        .fetch_redirect_valid (fetch_redirect_valid),
        .result_valid         (result_valid),
        .result_rob_id        (result_rob_id),
        .result_data          (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, want);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int_issue_pkg::alu_op_t pick_op();
        case (take_bits(4) % 10)
            0: return int_issue_pkg::alu_add;
            1: return int_issue_pkg::alu_sub;
            2: return int_issue_pkg::alu_sll;
            3: return int_issue_pkg::alu_slt;
            4: return int_issue_pkg::alu_sltu;
            5: return int_issue_pkg::alu_xor;
            6: return int_issue_pkg::alu_srl;
            7: return int_issue_pkg::alu_sra;
            8: return int_issue_pkg::alu_or;
            default: return int_issue_pkg::alu_and;
        endcase
    endfunction

    // rv32i semantics of each op
    function automatic logic [31:0] model_alu(input int_issue_pkg::alu_op_t op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            int_issue_pkg::alu_add:  return a + b;
            int_issue_pkg::alu_sub:  return a - b;
            int_issue_pkg::alu_sll:  return a << b[4:0];
            int_issue_pkg::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
            int_issue_pkg::alu_sltu: return {31'b0, a < b};
            int_issue_pkg::alu_xor:  return a ^ b;
            int_issue_pkg::alu_srl:  return a >> b[4:0];
            int_issue_pkg::alu_sra:  return $signed(a) >>> b[4:0];
            int_issue_pkg::alu_or:   return a | b;
            default:                 return a & b;
        endcase
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            if (issued_cnt[i] != done_cnt[i]) n++;
        end
        return n;
    endfunction

    // results seen by the model, flop style
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                done_cnt[i] <= '0;
            end
            result_count <= 0;
        end else if (result_valid) begin
            done_cnt[result_rob_id] <= done_cnt[result_rob_id] + 8'd1;
            result_count            <= result_count + 1;
        end
    end

    a_expected: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> issued_cnt[result_rob_id] != done_cnt[result_rob_id] &&
                         !waiting[result_rob_id])
        else report_error($sformatf("result for rob id %0d not expected now",
                                    $sampled(result_rob_id)));

    a_value: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> result_data == exp_val[result_rob_id])
        else report_mismatch("result_data", $sampled(result_data),
                             exp_val[$sampled(result_rob_id)]);

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && ordered |-> result_rob_id == order_ids[result_count - order_base])
        else report_mismatch("result_rob_id", 32'($sampled(result_rob_id)),
                             32'(order_ids[$sampled(result_count) - order_base]));

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        after_reset |-> !result_valid && dispatch_ready)
        else report_error("result_valid high or dispatch_ready low after reset");

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        expect_full |-> !dispatch_ready)
        else report_error("dispatch_ready high with a full queue");

    // called right after a falling edge, returns right after the next one
    task automatic dispatch(input int_issue_pkg::iiq_entry_t e, input logic [31:0] val);
        int t;
        t = 0;
        dispatch_valid = 1'b1;
        dispatch_data  = e;
        while (!dispatch_ready) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) report_error("dispatch_ready stayed low");
        end
        exp_val[e.instr_rob_id]    = val;
        issued_cnt[e.instr_rob_id] = issued_cnt[e.instr_rob_id] + 8'd1;
        after_reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    // random op with a ready src1, src2 ready or an immediate
    task automatic build_entry(input logic wait1, input int_issue_pkg::rob_id_t tag1,
                               input logic [31:0] a, output int_issue_pkg::iiq_entry_t e,
                               output logic [31:0] b);
        logic        sgn;
        logic [11:0] lo;
        e              = '0;
        e.src1_valid   = 1'b1;
        e.src1_rob_id  = wait1 ? tag1 : next_id;   // own tag, never broadcast while queued
        e.src1_ready   = !wait1;
        e.src1_data    = wait1 ? 32'h0 : a;
        e.use_imm      = 1'(take_bits(1));
        e.src2_valid   = !e.use_imm;
        e.src2_rob_id  = next_id;
        e.src2_ready   = 1'b1;
        e.src2_data    = take_bits(32);
        sgn            = 1'(take_bits(1));
        lo             = 12'(take_bits(12));
        e.imm          = {{20{sgn}}, lo};
        e.alu_op       = pick_op();
        e.dst_valid    = 1'b1;
        e.instr_rob_id = next_id;
        next_id++;
        b              = e.use_imm ? e.imm : e.src2_data;
    endtask

    task automatic pulse_load(input int_issue_pkg::rob_id_t tag, input logic [31:0] data);
        ld_broadcast_valid    = 1'b1;
        ld_broadcast_rob_id   = tag;
        ld_broadcast_reg_data = data;
        waiting               = '0;
        @(negedge clk);
        ld_broadcast_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (outstanding() != 0) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) report_error("dispatched entries never produced a result");
        end
    endtask

    initial begin
        int_issue_pkg::iiq_entry_t e;
        logic [31:0]               a;
        logic [31:0]               b;
        logic [31:0]               ld_data;
        int_issue_pkg::rob_id_t    prev;
        int_issue_pkg::rob_id_t    ld_tag;
        int                        t;

        lfsr                  = 32'h8eb49686;
        rst_n                 = 1'b0;
        dispatch_valid        = 1'b0;
        dispatch_data         = '0;
        ld_broadcast_valid    = 1'b0;
        ld_broadcast_rob_id   = '0;
        ld_broadcast_reg_data = '0;
        fetch_redirect_valid  = 1'b0;
        waiting               = '0;
        ordered               = 1'b0;
        after_reset           = 1'b0;
        expect_full           = 1'b0;
        order_base            = 0;
        next_id               = '0;
        for (int i = 0; i < 32; i++) begin
            exp_val[i]    = '0;
            issued_cnt[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n       = 1'b1;
        after_reset = 1'b1;
        repeat (3) @(negedge clk);

        // independent ops, sources ready on arrival
        for (int i = 0; i < 12; i++) begin
            a = take_bits(32);
            build_entry(1'b0, '0, a, e, b);
            dispatch(e, model_alu(e.alu_op, a, b));
        end
        wait_drained();

        // dependent chain on alu producers
        a = take_bits(32);
        build_entry(1'b0, '0, a, e, b);
        dispatch(e, model_alu(e.alu_op, a, b));
        prev = e.instr_rob_id;
        for (int i = 0; i < 8; i++) begin
            build_entry(1'b1, prev, 32'h0, e, b);
            dispatch(e, model_alu(e.alu_op, exp_val[prev], b));
            prev = e.instr_rob_id;
        end
        wait_drained();

        // consumers of a load result
        ld_tag  = next_id;
        next_id++;
        ld_data = take_bits(32);
        for (int i = 0; i < 3; i++) begin
            build_entry(1'b1, ld_tag, 32'h0, e, b);
            waiting[e.instr_rob_id] = 1'b1;
            dispatch(e, model_alu(e.alu_op, ld_data, b));
            if (i == 0) prev = e.instr_rob_id;
        end
        // woken by the first consumer while older ones still issue, so it captures
        build_entry(1'b1, prev, 32'h0, e, b);
        waiting[e.instr_rob_id] = 1'b1;
        dispatch(e, model_alu(e.alu_op, exp_val[prev], b));
        repeat (5) @(negedge clk);
        pulse_load(ld_tag, ld_data);
        wait_drained();

        // fill the queue, then drain oldest first
        ld_tag  = next_id;
        next_id++;
        ld_data = take_bits(32);
        for (int i = 0; i < n_entries; i++) begin
            build_entry(1'b1, ld_tag, 32'h0, e, b);
            order_ids[i] = e.instr_rob_id;
            dispatch(e, model_alu(e.alu_op, ld_data, b));
        end
        expect_full = 1'b1;
        repeat (3) @(negedge clk);
        expect_full = 1'b0;
        order_base  = result_count;
        ordered     = 1'b1;
        pulse_load(ld_tag, ld_data);
        wait_drained();
        ordered = 1'b0;
        t = 0;
        while (!dispatch_ready) begin
            @(negedge clk);
            t++;
            if (t > wait_limit) report_error("dispatch_ready did not rise after draining");
        end

        // flush blocked entries, their load arrives too late
        ld_tag  = next_id;
        next_id++;
        ld_data = take_bits(32);
        for (int i = 0; i < 4; i++) begin
            build_entry(1'b1, ld_tag, 32'h0, e, b);
            dispatch(e, model_alu(e.alu_op, ld_data, b));
        end
        // ready op picked in the flush cycle, killed on its way into the issue buffer
        a = take_bits(32);
        build_entry(1'b0, '0, a, e, b);
        dispatch(e, model_alu(e.alu_op, a, b));
        fetch_redirect_valid = 1'b1;
        for (int i = 0; i < 32; i++) begin
            issued_cnt[i] = done_cnt[i];
        end
        @(negedge clk);
        fetch_redirect_valid = 1'b0;
        pulse_load(ld_tag, ld_data);
        repeat (6) @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            a = take_bits(32);
            build_entry(1'b0, '0, a, e, b);
            dispatch(e, model_alu(e.alu_op, a, b));
        end
        wait_drained();
        repeat (4) @(negedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- project.f
design/int_issue_pkg.sv
design/shift_queue.sv
design/integer_alu.sv
design/integer_issue.sv
design/int_exec_top.sv
test/int_exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= int_exec_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
